/* files.f */
mduPkg.sv
mduController.sv
mduTimer.sv
mduArith.sv
hiLoRegs.sv
mduTop.sv
mduChecker_checker.sv
mduMonitor.sv
mduTb.sv

/* mduTb.sv */
`default_nettype none
`timescale 1ns/1ps

module mduTb;

    localparam int mulLatency  = 5;
    localparam int divLatency  = 10;
    localparam int resetCycles = 16;
    localparam int numRows     = 20;
    localparam int maxFlush    = 3;
    localparam int cycleLimit  = numRows * (divLatency + maxFlush + 4) + resetCycles;

    typedef struct packed {
        mduPkg::mduOp op;
        logic [31:0]  srcA;
        logic [31:0]  srcB;
        logic [1:0]   flushCycles;  // Flush cycles right after the start is taken.
        logic         randomOps;    // Operands come from the LFSR instead.
        logic         startInFlush; // Start is sent with flush high and must be dropped.
    } testRow;

    logic          clk;
    logic          reset;
    logic          start;
    logic          flush;
    mduPkg::mduReq req;
    logic          busy;
    logic [31:0]   hi;
    logic [31:0]   lo;
    int            testCount;
    int            failCount;
    int            mismatchCount;
    int            cycleCount = 0;
    int            rowFill    = 0;
    logic [31:0]   lfsrState  = 32'ha881c9b7;
    testRow        rowTable [0:numRows-1];

    mduTop #(.mulLatency(mulLatency), .divLatency(divLatency)) uut (
        .clk(clk), .reset(reset), .start(start), .req(req),
        .flush(flush), .busy(busy), .hi(hi), .lo(lo)
    );

    mduMonitor #(.mulLatency(mulLatency), .divLatency(divLatency)) monitor (
        .clk(clk), .reset(reset), .start(start), .req(req), .flush(flush),
        .busy(busy), .hi(hi), .lo(lo), .testCount(testCount),
        .failCount(failCount), .mismatchCount(mismatchCount)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2 and 1 give a maximal-length sequence.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawWord(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word      = {word[30:0], lfsrState[31]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic addRow(input mduPkg::mduOp op, input logic [31:0] a, input logic [31:0] b,
                          input logic [1:0] fl, input logic rnd, input logic inFlush);
        rowTable[rowFill] = {op, a, b, fl, rnd, inFlush};
        rowFill = rowFill + 1;
    endtask

    initial begin
        testRow      row;
        logic [31:0] a;
        logic [31:0] b;
        clk   = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        flush = 1'b0;
        req   = '0;
        addRow(mduPkg::opMthi,  32'h1234_5678, 32'h0,          2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMtlo,  32'h9abc_def0, 32'h0,          2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMult,  32'hffff_fffe, 32'h0000_0003, 2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMultu, 32'hffff_ffff, 32'hffff_ffff, 2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMult,  32'h8000_0000, 32'h8000_0000, 2'd2, 1'b0, 1'b0);
        addRow(mduPkg::opDiv,   32'hffff_fff9, 32'h0000_0002, 2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opDivu,  32'd100,       32'd7,         2'd1, 1'b0, 1'b0);
        addRow(mduPkg::opDiv,   32'h8765_4321, 32'h0,          2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opDivu,  32'h0000_beef, 32'h0,          2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opDiv,   32'h8000_0000, 32'hffff_ffff, 2'd3, 1'b0, 1'b0);
        addRow(mduPkg::opMthi,  32'h0000_0001, 32'h0,          2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMtlo,  32'hffff_fff0, 32'h0,          2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMadd,  32'h0000_0003, 32'hffff_fffb, 2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMaddu, 32'hffff_ffff, 32'h0000_0002, 2'd1, 1'b0, 1'b0);
        addRow(mduPkg::opMsub,  32'hffff_fffc, 32'h0000_0006, 2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMsubu, 32'h0001_0000, 32'h0001_0000, 2'd0, 1'b0, 1'b0);
        addRow(mduPkg::opMthi,  32'hdead_beef, 32'h0,          2'd0, 1'b0, 1'b1);
        addRow(mduPkg::opMult,  32'h0000_0007, 32'h0000_0009, 2'd0, 1'b0, 1'b1);
        addRow(mduPkg::opMadd,  32'h0,         32'h0,          2'd2, 1'b1, 1'b0);
        addRow(mduPkg::opDiv,   32'h0,         32'h0,          2'd3, 1'b1, 1'b0);

        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;

        for (int r = 0; r < numRows; r++) begin
            row = rowTable[r];
            a   = row.srcA;
            b   = row.srcB;
            if (row.randomOps) begin
                drawWord(a);
                drawWord(b);
            end
            req   = {row.op, a, b};
            start = 1'b1;
            flush = row.startInFlush;
            @(posedge clk);
            #1;
            start = 1'b0;
            flush = 1'b0;
            if (row.startInFlush || row.op == mduPkg::opMthi || row.op == mduPkg::opMtlo) begin
                @(posedge clk); // Moves and dropped starts settle within one cycle.
                #1;
            end else begin
                repeat (row.flushCycles) begin
                    flush = 1'b1;
                    @(posedge clk);
                    #1;
                end
                flush = 1'b0;
                while (busy === 1'b1) begin
                    @(posedge clk);
                    #1;
                end
            end
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Tests run %0d, failed %0d, mismatches %0d", testCount, failCount,
                 mismatchCount);
        if (testCount == numRows && failCount == 0 && mismatchCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            if (testCount != numRows) begin
                $display("Only %0d of %0d tests finished", testCount, numRows);
            end
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mduMonitor.sv */
`default_nettype none
`timescale 1ns/1ps

module mduMonitor #(
    parameter int mulLatency = 5,
    parameter int divLatency = 10
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  start,
    input  mduPkg::mduReq        req,
    input  wire                  flush,
    input  wire                  busy,
    input  wire           [31:0] hi,
    input  wire           [31:0] lo,
    output int                   testCount,
    output int                   failCount,
    output int                   mismatchCount
);

    logic [31:0]  modelHi;
    logic [31:0]  modelLo;
    logic [63:0]  accNow;    // Model HI:LO at the moment a request is taken.
    logic [63:0]  pending;   // Result waiting for its commit edge.
    int           remaining; // Edges left until commit, zero when idle.
    int           testErrors;
    logic [1:0]   doneKind;  // 1 commit, 2 move, 3 start ignored under flush.
    mduPkg::mduOp lastOp;

    function automatic logic [63:0] product(input logic [31:0] a, input logic [31:0] b,
                                            input logic signedOp);
        logic [63:0] wideA;
        logic [63:0] wideB;
        wideA = signedOp ? {{32{a[31]}}, a} : {32'b0, a};
        wideB = signedOp ? {{32{b[31]}}, b} : {32'b0, b};
        return wideA * wideB; // Only the low 64 bits matter.
    endfunction

    // Returns the remainder in the upper word and the quotient in the lower word.
    function automatic logic [63:0] divide(input logic [31:0] a, input logic [31:0] b,
                                           input logic signedOp);
        logic        negA;
        logic        negB;
        logic [31:0] magA;
        logic [31:0] magB;
        logic [31:0] quot;
        logic [31:0] rem;
        negA = signedOp && a[31];
        negB = signedOp && b[31];
        magA = negA ? -a : a;
        magB = negB ? -b : b;
        if (b == 32'd0) begin
            return {a, 32'hffff_ffff};
        end
        // The most negative value over minus one wraps back to itself with a zero remainder.
        quot = magA / magB;
        rem  = magA % magB;
        if (negA != negB) quot = -quot;
        if (negA) rem = -rem; // The remainder follows the dividend's sign.
        return {rem, quot};
    endfunction

    always @(posedge clk) begin
        doneKind = 2'd0;
        if (reset) begin
            modelHi   = '0;
            modelLo   = '0;
            remaining = 0;
        end else if (remaining == 1) begin
            {modelHi, modelLo} = pending;
            remaining = 0;
            doneKind  = 2'd1;
        end else if (remaining > 1) begin
            if (!flush) remaining = remaining - 1; // Flush freezes the countdown.
        end else if (start) begin
            lastOp = req.op;
            if (flush) begin
                doneKind = 2'd3;
            end else begin
                accNow = {modelHi, modelLo};
                case (req.op)
                    mduPkg::opMthi: begin
                        modelHi  = req.srcA;
                        doneKind = 2'd2;
                    end
                    mduPkg::opMtlo: begin
                        modelLo  = req.srcA;
                        doneKind = 2'd2;
                    end
                    mduPkg::opMult:  pending = product(req.srcA, req.srcB, 1'b1);
                    mduPkg::opMultu: pending = product(req.srcA, req.srcB, 1'b0);
                    mduPkg::opMadd:  pending = accNow + product(req.srcA, req.srcB, 1'b1);
                    mduPkg::opMaddu: pending = accNow + product(req.srcA, req.srcB, 1'b0);
                    mduPkg::opMsub:  pending = accNow - product(req.srcA, req.srcB, 1'b1);
                    mduPkg::opMsubu: pending = accNow - product(req.srcA, req.srcB, 1'b0);
                    mduPkg::opDiv:   pending = divide(req.srcA, req.srcB, 1'b1);
                    mduPkg::opDivu:  pending = divide(req.srcA, req.srcB, 1'b0);
                    default:         ;
                endcase
                if (req.op == mduPkg::opDiv || req.op == mduPkg::opDivu) begin
                    remaining = divLatency;
                end else if (doneKind == 2'd0 && req.op != mduPkg::opNone &&
                             req.op <= mduPkg::opMsubu) begin
                    remaining = mulLatency;
                end
            end
        end
    end

    task automatic compareWord(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            testErrors    = testErrors + 1;
            mismatchCount = mismatchCount + 1;
        end
    endtask

    // Outputs are compared half a cycle after the edge, once they have settled.
    always @(negedge clk) begin
        if (reset) begin
            testCount     = 0;
            failCount     = 0;
            mismatchCount = 0;
            testErrors    = 0;
        end else begin
            compareWord("busy", {31'b0, remaining != 0}, {31'b0, busy});
            compareWord("hi", modelHi, hi);
            compareWord("lo", modelLo, lo);
            if (doneKind != 2'd0) begin
                testCount = testCount + 1;
                if (testErrors == 0) begin
                    $display("Test %0d (op %0d, kind %0d) ok", testCount, lastOp, doneKind);
                end else begin
                    $display("Test %0d (op %0d, kind %0d) failed with %0d mismatches",
                             testCount, lastOp, doneKind, testErrors);
                    failCount = failCount + 1;
                end
                testErrors = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* mduChecker_checker.sv */
`default_nettype none
`timescale 1ns/1ps

module mduChecker (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  start,
    input  mduPkg::mduReq        req,
    input  wire                  flush,
    input  wire                  busy,
    input  wire           [31:0] hi,
    input  wire           [31:0] lo
);

    logic moveReq;

    assign moveReq = start && ((req.op == mduPkg::opMthi) || (req.op == mduPkg::opMtlo));

    busyAfterReset: assert property (@(posedge clk) reset |=> !busy)
        else $error("busy is high right after reset");

    moveNotBusy: assert property (@(posedge clk) disable iff (reset)
        (moveReq && !busy) |=> !busy)
        else $error("busy rose on a move to HI or LO");

    flushBlocksStart: assert property (@(posedge clk) disable iff (reset)
        (start && flush && !busy) |=> !busy)
        else $error("a start was taken while flush was high");

    // HI and LO may only change on the edge where busy falls.
    stableWhileBusy: assert property (@(posedge clk) disable iff (reset)
        busy |=> (!busy || ($stable(hi) && $stable(lo))))
        else $error("HI or LO changed while busy was high");

endmodule

bind mduTop mduChecker flowCheck (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .req   (req),
    .flush (flush),
    .busy  (busy),
    .hi    (hi),
    .lo    (lo)
);

`default_nettype wire

/* mduTop.sv */
`default_nettype none
`timescale 1ns/1ps

module mduTop #(
    parameter int mulLatency = 5,  // Cycles from accept to commit for multiplies.
    parameter int divLatency = 10  // Cycles from accept to commit for divides.
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  mduPkg::mduReq         req,
    input  wire                   flush,
    output logic                  busy,
    output logic           [31:0] hi,
    output logic           [31:0] lo
);

    logic           capture;
    logic           load;
    logic           longOp;
    logic           moveHi;
    logic           moveLo;
    logic           commit;
    logic           expire;
    mduPkg::accWord result;

    mduController controller (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .op      (req.op),
        .flush   (flush),
        .expire  (expire),
        .capture (capture),
        .load    (load),
        .longOp  (longOp),
        .moveHi  (moveHi),
        .moveLo  (moveLo),
        .commit  (commit),
        .busy    (busy)
    );

    // Flush freezes the countdown.
    mduTimer #(
        .mulLatency (mulLatency),
        .divLatency (divLatency)
    ) timer (
        .clk    (clk),
        .reset  (reset),
        .load   (load),
        .longOp (longOp),
        .hold   (flush),
        .expire (expire)
    );

    mduArith arith (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .req     (req),
        .hi      (hi),
        .lo      (lo),
        .result  (result)
    );

    hiLoRegs regs (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .moveHi   (moveHi),
        .moveLo   (moveLo),
        .result   (result),
        .moveData (req.srcA),
        .hi       (hi),
        .lo       (lo)
    );

endmodule

`default_nettype wire

/* hiLoRegs.sv */
`default_nettype none
`timescale 1ns/1ps

module hiLoRegs (
    input  wire             clk,
    input  wire             reset,
    input  wire             commit,
    input  wire             moveHi,
    input  wire             moveLo,
    input  mduPkg::accWord  result,
    input  wire      [31:0] moveData,
    output logic     [31:0] hi,
    output logic     [31:0] lo
);

    // Commit and the moves are never high together.
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
        end else if (commit) begin
            hi <= result.half.hi;
        end else if (moveHi) begin
            hi <= moveData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lo <= '0;
        end else if (commit) begin
            lo <= result.half.lo; // Quotient or low product word.
        end else if (moveLo) begin
            lo <= moveData;
        end
    end

endmodule

`default_nettype wire

/* mduArith.sv */
`default_nettype none
`timescale 1ns/1ps

module mduArith (
    input  wire            clk,
    input  wire            reset,
    input  wire            capture,
    input  mduPkg::mduReq  req,
    input  wire     [31:0] hi,
    input  wire     [31:0] lo,
    output mduPkg::accWord result
);

    mduPkg::accWord prev;
    mduPkg::accWord nextResult;
    logic [63:0]    sProd;
    logic [63:0]    uProd;
    logic [31:0]    sQuotRaw;
    logic [31:0]    sRemRaw;
    logic [31:0]    sQuot;
    logic [31:0]    sRem;
    logic [31:0]    uQuot;
    logic [31:0]    uRem;
    logic           divZero;
    logic           divOvf;

    assign prev.full = {hi, lo};

    // Both operands are signed here, so they are sign-extended to 64 bits.
    assign sProd = $signed(req.srcA) * $signed(req.srcB);
    assign uProd = req.srcA * req.srcB; // Zero-extended to the 64-bit target.

    assign divZero = (req.srcB == '0);
    assign divOvf  = (req.srcA == 32'h8000_0000) && (req.srcB == 32'hffff_ffff);

    // Raw results are kept apart from the muxes below so that the unsigned
    // constants there cannot turn the signed divide into an unsigned one.
    assign sQuotRaw = $signed(req.srcA) / $signed(req.srcB);
    assign sRemRaw  = $signed(req.srcA) % $signed(req.srcB);

    always_comb begin
        if (divZero) begin
            sQuot = '1;
            sRem  = req.srcA;
        end else if (divOvf) begin
            sQuot = 32'h8000_0000;
            sRem  = '0;
        end else begin
            sQuot = sQuotRaw;
            sRem  = sRemRaw;
        end
    end

    assign uQuot = divZero ? '1 : (req.srcA / req.srcB);
    assign uRem  = divZero ? req.srcA : (req.srcA % req.srcB);

    always_comb begin
        nextResult = result;
        case (req.op)
            mduPkg::opMult:  nextResult.full = sProd;
            mduPkg::opMultu: nextResult.full = uProd;
            mduPkg::opMadd:  nextResult.full = prev.full + sProd; // Wraps at 64 bits.
            mduPkg::opMaddu: nextResult.full = prev.full + uProd;
            mduPkg::opMsub:  nextResult.full = prev.full - sProd;
            mduPkg::opMsubu: nextResult.full = prev.full - uProd;
            mduPkg::opDiv: begin
                nextResult.half.hi = sRem;
                nextResult.half.lo = sQuot;
            end
            mduPkg::opDivu: begin
                nextResult.half.hi = uRem;
                nextResult.half.lo = uQuot;
            end
            default: nextResult = result; // Moves leave the held result alone.
        endcase
    end

    // The outcome stays here until hiLoRegs takes it on commit.
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (capture) begin
            result <= nextResult;
        end
    end

endmodule

`default_nettype wire

/* mduTimer.sv */
`default_nettype none
`timescale 1ns/1ps

module mduTimer #(
    parameter int mulLatency = 5,
    parameter int divLatency = 10
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  load,
    input  wire  longOp,
    input  wire  hold,
    output logic expire
);

    localparam int maxLatency = (divLatency > mulLatency) ? divLatency : mulLatency;
    localparam int cntW       = $clog2(maxLatency + 1);

    logic [cntW-1:0] count;

    // The commit cycle in the controller takes up the last cycle of the
    // latency, so the count starts one short of it.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= longOp ? cntW'(divLatency - 1) : cntW'(mulLatency - 1);
        end else if (!hold && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    assign expire = (count == cntW'(1));

endmodule

`default_nettype wire

/* mduController.sv */
`default_nettype none
`timescale 1ns/1ps

module mduController (
    input  wire          clk,
    input  wire          reset,
    input  wire          start,
    input  mduPkg::mduOp op,
    input  wire          flush,
    input  wire          expire,
    output logic         capture,
    output logic         load,
    output logic         longOp,
    output logic         moveHi,
    output logic         moveLo,
    output logic         commit,
    output logic         busy
);

    typedef enum logic [1:0] {
        idle,
        running,
        committing
    } ctrlState;

    ctrlState state;
    ctrlState nextState;
    logic     accept;
    logic     isTimed;

    // Decode which operations go through the timer.
    always_comb begin
        isTimed = 1'b0;
        case (op)
            mduPkg::opMult,
            mduPkg::opMultu,
            mduPkg::opDiv,
            mduPkg::opDivu,
            mduPkg::opMadd,
            mduPkg::opMaddu,
            mduPkg::opMsub,
            mduPkg::opMsubu: isTimed = 1'b1;
            default:         isTimed = 1'b0; // Moves, opNone and unused codes.
        endcase
    end

    // A start is only taken when the unit is free and no exception is pending.
    assign accept  = start && !flush && (state == idle);
    assign capture = accept;
    assign load    = accept && isTimed;
    assign longOp  = (op == mduPkg::opDiv) || (op == mduPkg::opDivu);
    assign moveHi  = accept && (op == mduPkg::opMthi);
    assign moveLo  = accept && (op == mduPkg::opMtlo);

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (load) begin
                    nextState = running;
                end
            end
            running: begin
                // The timer holds under flush, so the FSM must hold too.
                if (expire && !flush) begin
                    nextState = committing;
                end
            end
            committing: nextState = idle;
            default:    nextState = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    assign commit = (state == committing); // HI and LO load at the end of this cycle.
    assign busy   = (state != idle);

endmodule

`default_nettype wire

/* mduPkg.sv */
`default_nettype none

package mduPkg;

    // Operation codes seen by the multiply/divide unit.
    typedef enum logic [3:0] {
        opNone  = 4'd0,  // No operation.
        opMult  = 4'd1,  // Signed multiply.
        opMultu = 4'd2,  // Unsigned multiply.
        opDiv   = 4'd3,  // Signed divide.
        opDivu  = 4'd4,  // Unsigned divide.
        opMthi  = 4'd5,  // Move srcA into HI.
        opMtlo  = 4'd6,  // Move srcA into LO.
        opMadd  = 4'd7,  // HI:LO plus signed product.
        opMaddu = 4'd8,  // HI:LO plus unsigned product.
        opMsub  = 4'd9,  // HI:LO minus signed product.
        opMsubu = 4'd10  // HI:LO minus unsigned product.
    } mduOp;

    // One request, sampled on the start strobe.
    typedef struct packed {
        mduOp        op;
        logic [31:0] srcA;
        logic [31:0] srcB;
    } mduReq;

    // The two architectural halves of the 64-bit accumulator.
    typedef struct packed {
        logic [31:0] hi; // Upper word, or the remainder of a divide.
        logic [31:0] lo; // Lower word, or the quotient of a divide.
    } accHalves;

    // Multiply and accumulate work on the whole 64-bit number, while divides
    // and the register commit deal in the separate HI and LO words.
    typedef union packed {
        logic [63:0] full;
        accHalves    half;
    } accWord;

endpackage

`default_nettype wire
